/* rtl/core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	localparam int NUM_REGS = 32;

	typedef enum logic [1:0] {
		FETCH,
		LOAD_INSTR,
		EXECUTE,
		WRITEBACK
	} state_t;

	// blt and bltu reuse the slt and sltu codes
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B, // lui
		ALU_BEQ,
		ALU_BNE,
		ALU_BGE,
		ALU_BGEU
	} alu_op_t;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// major opcodes kept by this core
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_BRANCH = 7'b1100011;

	// alu group, shared by reg and imm forms
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// branch compares
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct7_t FUNCT7_ALT = 7'b0100000; // sub, sra, srai

endpackage

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  core_pkg::word_t    ir,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	output core_pkg::reg_idx_t rd,
	output core_pkg::word_t    imm,
	output logic               use_imm,
	output core_pkg::alu_op_t  alu_op,
	output logic               reg_write,
	output logic               is_branch
);
	import core_pkg::*;
	import isa_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	logic    plain;
	logic    alt;

	function automatic alu_op_t arith_op(input funct3_t f3, input logic sel_alt);
		case (f3)
			F3_ADD_SUB: return sel_alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     return ALU_SLL;
			F3_SLT:     return ALU_SLT;
			F3_SLTU:    return ALU_SLTU;
			F3_XOR:     return ALU_XOR;
			F3_SRL_SRA: return sel_alt ? ALU_SRA : ALU_SRL;
			F3_OR:      return ALU_OR;
			default:    return ALU_AND;
		endcase
	endfunction

	assign opcode = ir[6:0];
	assign rd     = ir[11:7];
	assign funct3 = ir[14:12];
	assign rs1    = ir[19:15];
	assign rs2    = ir[24:20];
	assign funct7 = ir[31:25];
	assign plain  = (funct7 == '0);
	assign alt    = (funct7 == FUNCT7_ALT);

	always_comb begin
		imm       = '0;
		use_imm   = 1'b0;
		alu_op    = ALU_ADD;
		reg_write = 1'b0;
		is_branch = 1'b0;
		case (opcode)
			OP_REG: begin
				alu_op    = arith_op(funct3, alt);
				reg_write = plain || (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
			end
			OP_IMM: begin
				imm       = {{20{ir[31]}}, ir[31:20]};
				use_imm   = 1'b1;
				alu_op    = arith_op(funct3, alt && funct3 == F3_SRL_SRA); // addi has no sub
				if (funct3 == F3_SLL)
					reg_write = plain;
				else if (funct3 == F3_SRL_SRA)
					reg_write = plain || alt;
				else
					reg_write = 1'b1;
			end
			OP_LUI: begin
				imm       = {ir[31:12], 12'b0};
				use_imm   = 1'b1;
				alu_op    = ALU_PASS_B;
				reg_write = 1'b1;
			end
			OP_BRANCH: begin
				imm       = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
				is_branch = 1'b1;
				case (funct3)
					F3_BEQ:  alu_op = ALU_BEQ;
					F3_BNE:  alu_op = ALU_BNE;
					F3_BLT:  alu_op = ALU_SLT;
					F3_BGE:  alu_op = ALU_BGE;
					F3_BLTU: alu_op = ALU_SLTU;
					F3_BGEU: alu_op = ALU_BGEU;
					default: is_branch = 1'b0; // 010 and 011 unused
				endcase
			end
			default: ; // unknown opcode retires as a no-op
		endcase
	end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  core_pkg::word_t   a,
	input  core_pkg::word_t   b_reg,
	input  core_pkg::word_t   imm,
	input  logic              use_imm,
	input  core_pkg::alu_op_t alu_op,
	output core_pkg::word_t   result,
	output logic              branch_taken
);
	import core_pkg::*;

	word_t      op_b;
	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;
	logic       br_lt_s;
	logic       br_lt_u;

	assign op_b  = use_imm ? imm : b_reg;
	assign shamt = op_b[4:0];
	assign lt_s  = $signed(a) < $signed(op_b);
	assign lt_u  = a < op_b;

	// branches always compare against the register operand
	assign br_lt_s = $signed(a) < $signed(b_reg);
	assign br_lt_u = a < b_reg;

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = a + op_b;
			ALU_SUB:    result = a - op_b;
			ALU_XOR:    result = a ^ op_b;
			ALU_OR:     result = a | op_b;
			ALU_AND:    result = a & op_b;
			ALU_SLL:    result = a << shamt;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = $signed(a) >>> shamt;
			ALU_SLT:    result = {31'b0, lt_s};
			ALU_SLTU:   result = {31'b0, lt_u};
			ALU_PASS_B: result = op_b;
			default:    result = '0;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_BEQ:  branch_taken = (a == b_reg);
			ALU_BNE:  branch_taken = (a != b_reg);
			ALU_SLT:  branch_taken = br_lt_s; // blt
			ALU_BGE:  branch_taken = !br_lt_s;
			ALU_SLTU: branch_taken = br_lt_u; // bltu
			ALU_BGEU: branch_taken = !br_lt_u;
			default:  branch_taken = 1'b0;
		endcase
	end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	output core_pkg::word_t    rs1_data,
	output core_pkg::word_t    rs2_data,
	input  logic               wr_en,
	input  core_pkg::reg_idx_t wr_idx,
	input  core_pkg::word_t    wr_data
);
	import core_pkg::*;

	word_t regs [NUM_REGS];

	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	// x0 stays zero since writes to index 0 never arrive
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

/* rtl/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm #(
	parameter core_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst,
	output logic               fetch,
	output core_pkg::word_t    instr_addr,
	input  core_pkg::word_t    instr,
	output core_pkg::word_t    ir,
	input  core_pkg::reg_idx_t rd,
	input  logic               reg_write,
	input  logic               is_branch,
	input  core_pkg::word_t    imm,
	input  core_pkg::word_t    alu_result,
	input  logic               branch_taken,
	output logic               wr_en,
	output core_pkg::reg_idx_t wr_idx,
	output core_pkg::word_t    wr_data,
	output logic               retire,
	output core_pkg::word_t    retire_pc,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_data
);
	import core_pkg::*;

	state_t state;
	word_t  pc;
	word_t  next_pc;
	logic   writes_rd;

	assign instr_addr = pc;
	assign writes_rd  = reg_write && (rd != '0);
	assign wr_idx     = retire_rd; // retire record doubles as write port
	assign wr_data    = retire_data;

	// reset parks in writeback with strobes low, so fetch follows on the first edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= WRITEBACK;
			pc          <= reset_pc;
			next_pc     <= reset_pc;
			fetch       <= 1'b0;
			retire      <= 1'b0;
			wr_en       <= 1'b0;
			retire_pc   <= '0;
			retire_rd   <= '0;
			retire_data <= '0;
		end else begin
			case (state)
				FETCH: begin
					fetch <= 1'b0;
					state <= LOAD_INSTR;
				end
				LOAD_INSTR: begin
					state <= EXECUTE;
				end
				EXECUTE: begin
					next_pc     <= (is_branch && branch_taken) ? pc + imm : pc + 32'd4;
					retire      <= 1'b1;
					wr_en       <= writes_rd;
					retire_pc   <= pc;
					retire_rd   <= writes_rd ? rd : '0;
					retire_data <= writes_rd ? alu_result : '0;
					state       <= WRITEBACK;
				end
				WRITEBACK: begin
					retire <= 1'b0;
					wr_en  <= 1'b0;
					pc     <= next_pc;
					fetch  <= 1'b1;
					state  <= FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == LOAD_INSTR)
			ir <= instr; // instr held since the fetch edge
	end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter core_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst,
	output logic               fetch,
	output core_pkg::word_t    instr_addr,
	input  core_pkg::word_t    instr,
	output logic               retire,
	output core_pkg::word_t    retire_pc,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_data
);
	import core_pkg::*;

	word_t    ir;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t    imm;
	logic     use_imm;
	alu_op_t  alu_op;
	logic     reg_write;
	logic     is_branch;
	word_t    rs1_data;
	word_t    rs2_data;
	word_t    alu_result;
	logic     branch_taken;
	logic     wr_en;
	reg_idx_t wr_idx;
	word_t    wr_data;

	control_fsm #(
		.reset_pc(reset_pc)
	) control_fsm_inst (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.instr_addr(instr_addr),
		.instr(instr),
		.ir(ir),
		.rd(rd),
		.reg_write(reg_write),
		.is_branch(is_branch),
		.imm(imm),
		.alu_result(alu_result),
		.branch_taken(branch_taken),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.retire(retire),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	instr_decoder instr_decoder_inst (
		.ir(ir),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.imm(imm),
		.use_imm(use_imm),
		.alu_op(alu_op),
		.reg_write(reg_write),
		.is_branch(is_branch)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.rst(rst),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data)
	);

	alu alu_inst (
		.a(rs1_data),
		.b_reg(rs2_data),
		.imm(imm),
		.use_imm(use_imm),
		.alu_op(alu_op),
		.result(alu_result),
		.branch_taken(branch_taken)
	);

endmodule

/* verification/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
	import core_pkg::*;

	localparam word_t START_PC   = 32'h0000_0000;
	localparam int    CLK_PERIOD = 40;
	localparam word_t NOP_INSTR  = 32'h0000_0013; // addi x0, x0, 0

	logic     clk;
	logic     rst;
	logic     fetch;
	word_t    instr_addr;
	word_t    instr;
	logic     retire;
	word_t    retire_pc;
	reg_idx_t retire_rd;
	word_t    retire_data;

	word_t    imem [word_t]; // instruction map by pc
	word_t    exp_pc [$];
	reg_idx_t exp_rd [$];
	word_t    exp_data [$];

	int   num_records = 0;
	int   value_errors = 0;
	int   timing_errors = 0;
	int   program_errors = 0;
	int   cycle = 0;
	int   last_fetch = 0;
	int   watchdog_ns = 0;
	logic seen_fetch = 1'b0;
	logic loaded = 1'b0;
	logic done = 1'b0;

	cpu_top #(
		.reset_pc(START_PC)
	) cpu_top_inst (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.instr_addr(instr_addr),
		.instr(instr),
		.retire(retire),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic load_program();
		int       fd;
		int       n;
		string    line;
		word_t    pc;
		word_t    word;
		reg_idx_t rd;
		word_t    value;
		fd = $fopen("verification/testdata_program.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/testdata_program.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%h %h %h %h", pc, word, rd, value) == 4) begin
					imem[pc] = word;
					exp_pc.push_back(pc);
					exp_rd.push_back(rd);
					exp_data.push_back(value);
					num_records++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic serve_fetch();
		if (!seen_fetch) begin
			check_word(instr_addr, START_PC, "first fetch address");
		end else if (cycle - last_fetch != 4) begin
			$display("fetch came %0d cycles after the previous one instead of 4 at %0t ns",
				cycle - last_fetch, $time);
			timing_errors++;
		end
		seen_fetch = 1'b1;
		last_fetch = cycle;
		if (imem.exists(instr_addr)) begin
			instr <= imem[instr_addr];
		end else begin
			$display("the core fetched address %h, which holds no instruction", instr_addr);
			program_errors++;
			instr <= NOP_INSTR;
		end
	endtask

	task automatic check_retire();
		if (!seen_fetch) begin
			$display("retire went high before the first fetch at %0t ns", $time);
			timing_errors++;
		end else if (cycle - last_fetch != 3) begin
			$display("retire came %0d cycles after its fetch instead of 3 at %0t ns",
				cycle - last_fetch, $time);
			timing_errors++;
		end
		check_word(retire_pc, exp_pc.pop_front(), "retire_pc");
		check_reg(retire_rd, exp_rd.pop_front(), "retire_rd");
		check_word(retire_data, exp_data.pop_front(), "retire_data");
		if (exp_pc.size() == 0)
			done = 1'b1;
	endtask

	task automatic report_counts();
		$display("errors: %0d value, %0d timing, %0d program, %0d of %0d records left",
			value_errors, timing_errors, program_errors, exp_pc.size(), num_records);
	endtask

	// outputs read here still hold the values from before this edge
	always @(posedge clk) begin
		if (!rst && !done) begin
			cycle++;
			if (fetch)
				serve_fetch();
			if (retire)
				check_retire();
		end
	end

	initial begin
		rst = 1'b1;
		instr = '0;
		load_program();
		if (num_records == 0) begin
			$display("no program records could be read, nothing to run");
			program_errors++;
		end else begin
			watchdog_ns = (num_records + 4) * 4 * CLK_PERIOD;
			loaded = 1'b1;
			repeat (2) @(posedge clk);
			rst <= 1'b0;
			wait (done);
		end
		report_counts();
		if (value_errors + timing_errors + program_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#(watchdog_ns);
		$display("timeout after %0d ns with records still waiting to retire", watchdog_ns);
		report_counts();
		$display("Regression failed");
		$finish;
	end

endmodule

/* verification/testdata_program.txt */
# pc       instr    rd value    (hex, one record per retirement, in retire order)
# rd and value are 0 for branches, writes to x0 and unknown opcodes
00000000 00500093 01 00000005
00000004 ffd00113 02 fffffffd
00000008 002081b3 03 00000002
0000000c 40110233 04 fffffff8
00000010 0020c2b3 05 fffffff8
00000014 0020e333 06 fffffffd
00000018 0020f3b3 07 00000005
0000001c 00309433 08 00000014
00000020 003254b3 09 3ffffffe
00000024 40325533 0a fffffffe
00000028 001125b3 0b 00000001
0000002c 00113633 0c 00000000
00000030 fff0c693 0d fffffffa
00000034 0f00e713 0e 000000f5
00000038 07f17793 0f 0000007d
0000003c 00409813 10 00000050
00000040 01c25893 11 0000000f
00000044 40125913 12 fffffffc
00000048 ffe12993 13 00000001
0000004c 00313a13 14 00000000
00000050 abcdeab7 15 abcde000
00000054 00708013 00 00000000
00000058 00100b33 16 00000005
0000005c 00708463 00 00000000
00000064 00709463 00 00000000
00000068 00114463 00 00000000
00000070 00116463 00 00000000
00000074 0020d663 00 00000000
00000080 0020f463 00 00000000
00000084 fe209ce3 00 00000000
0000007c 00000863 00 00000000
0000008c 12318b93 17 00000125
00000090 00000f8b 00 00000000
00000094 01fb8c33 18 00000125

/* tb.f */
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/control_fsm.sv
rtl/cpu_top.sv
verification/cpu_tb.sv
